/* include/glb_config.svh */
/*
 * Sizing of the global buffer: tile count, address split, data width
 * and the depth of the read-response FIFO at the east end.
 * Included by the package and by every module that sizes ports or storage.
 */
`ifndef GLB_CONFIG_SVH
`define GLB_CONFIG_SVH

// number of memory tiles in the chain
`define GLB_NUM_TILES 4

// word address inside one bank, 64 words per tile
`define GLB_BANK_ADDR_WIDTH 6

// upper word-address bits that pick the tile
`define GLB_TILE_SEL_WIDTH 2

// full host word address
`define GLB_ADDR_WIDTH (`GLB_TILE_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH)

`define GLB_DATA_WIDTH 32
`define GLB_STRB_WIDTH (`GLB_DATA_WIDTH / 8)

// response FIFO slots, equal to the read credits held by the ingress
`define GLB_RDRS_DEPTH 4

// wide enough to hold 0 .. GLB_RDRS_DEPTH
`define GLB_CREDIT_WIDTH 3

`endif

/* verilog/glb_pkg.sv */
/*
 * Types shared along the tile chain.
 * One lane word carries either a write or a read request; the kind bit
 * travelling next to it says which view of the union applies.
 */
`include "glb_config.svh"

package glb_pkg;

    typedef enum logic {
        GLB_REQ_WR = 1'b0,
        GLB_REQ_RD = 1'b1
    } glb_req_kind_e;

    // write view: strobes, word address, data
    typedef struct packed {
        logic [`GLB_STRB_WIDTH-1:0] strb;
        logic [`GLB_ADDR_WIDTH-1:0] addr;
        logic [`GLB_DATA_WIDTH-1:0] data;
    } glb_wr_req_t;

    // read view: address in the top bits, rest unused
    typedef struct packed {
        logic [`GLB_ADDR_WIDTH-1:0]                   addr;
        logic [`GLB_STRB_WIDTH+`GLB_DATA_WIDTH-1:0]   pad;
    } glb_rd_req_t;

    typedef union packed {
        glb_wr_req_t wr;
        glb_rd_req_t rd;
    } glb_req_u;

endpackage

/* verilog/glb_lane_if.sv */
/*
 * One west-to-east hop of the tile chain.
 * Request lane and response lane move together, one register stage per
 * tile. The sending side uses modport up, the receiving side modport dn.
 */
`timescale 1ns/1ps
`include "glb_config.svh"

interface glb_lane_if;
    import glb_pkg::*;

    logic                        req_valid;
    glb_req_kind_e               req_kind;
    glb_req_u                    req;
    logic                        rdrs_valid;
    logic [`GLB_DATA_WIDTH-1:0]  rdrs_data;

    modport up (
        output req_valid,
        output req_kind,
        output req,
        output rdrs_valid,
        output rdrs_data
    );

    modport dn (
        input req_valid,
        input req_kind,
        input req,
        input rdrs_valid,
        input rdrs_data
    );

endinterface

/* verilog/glb_proc_ingress.sv */
/*
 * Host side of the global buffer.
 * Registers one write or read per cycle onto lane 0 of the tile chain.
 * Reads are accepted only while a response credit is held, so the egress
 * FIFO can never overflow; writes always go through.
 */
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_proc_ingress (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        proc_wr_en,
    input  logic [`GLB_STRB_WIDTH-1:0]  proc_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]  proc_wr_data,
    input  logic                        proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic                        proc_rd_req_ready,
    input  logic                        credit_return,
    glb_lane_if.up                      lane_out
);
    import glb_pkg::*;

    logic [`GLB_CREDIT_WIDTH-1:0] credit_cnt;
    logic                         rd_accept;
    logic                         req_accept;
    glb_req_kind_e                req_kind_next;
    glb_req_u                     req_word_next;
    logic                         req_valid_q;
    glb_req_kind_e                req_kind_q;
    glb_req_u                     req_word_q;

    assign proc_rd_req_ready = (credit_cnt != '0);

    // write has priority over a read in the same cycle
    assign rd_accept  = proc_rd_en && proc_rd_req_ready && !proc_wr_en;
    assign req_accept = proc_wr_en || rd_accept;

    always_comb begin
        req_word_next = '0;
        if (proc_wr_en) begin
            req_kind_next         = GLB_REQ_WR;
            req_word_next.wr.strb = proc_wr_strb;
            req_word_next.wr.addr = proc_wr_addr;
            req_word_next.wr.data = proc_wr_data;
        end else begin
            req_kind_next         = GLB_REQ_RD;
            req_word_next.rd.addr = proc_rd_addr;
        end
    end

    // one credit per free FIFO slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_cnt <= `GLB_CREDIT_WIDTH'(`GLB_RDRS_DEPTH);
        end else begin
            case ({rd_accept, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_accept;
        end
    end

    // payload only loads on an accepted request
    always_ff @(posedge clk) begin
        if (req_accept) begin
            req_kind_q <= req_kind_next;
            req_word_q <= req_word_next;
        end
    end

    assign lane_out.req_valid  = req_valid_q;
    assign lane_out.req_kind   = req_kind_q;
    assign lane_out.req        = req_word_q;

    // nothing has been read yet at the west end
    assign lane_out.rdrs_valid = 1'b0;
    assign lane_out.rdrs_data  = '0;

endmodule

/* verilog/glb_tile.sv */
/*
 * One memory tile of the chain, owning the bank whose tile-select bits
 * equal TILE_ID. Every request is forwarded east one cycle later; a hit
 * writes the strobed bytes or puts the bank word on the response lane.
 * Instantiated once per tile from the top-level generate loop.
 */
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic    clk,
    input  logic    reset,
    glb_lane_if.dn  lane_in,
    glb_lane_if.up  lane_out
);
    import glb_pkg::*;

    localparam int BANK_WORDS = 2 ** `GLB_BANK_ADDR_WIDTH;

    logic [`GLB_DATA_WIDTH-1:0]      bank [BANK_WORDS];
    logic [`GLB_ADDR_WIDTH-1:0]      req_addr;
    logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr;
    logic                            tile_hit;
    logic                            wr_hit;
    logic                            rd_hit;

    logic                            req_valid_q;
    glb_req_kind_e                   req_kind_q;
    glb_req_u                        req_q;
    logic                            rdrs_valid_q;
    logic [`GLB_DATA_WIDTH-1:0]      rdrs_data_q;

    // the kind bit selects which view of the lane word holds the address
    assign req_addr  = (lane_in.req_kind == GLB_REQ_WR) ? lane_in.req.wr.addr
                                                         : lane_in.req.rd.addr;
    assign bank_addr = req_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign tile_hit  = lane_in.req_valid &&
        (req_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH] ==
         `GLB_TILE_SEL_WIDTH'(TILE_ID));
    assign wr_hit    = tile_hit && (lane_in.req_kind == GLB_REQ_WR);
    assign rd_hit    = tile_hit && (lane_in.req_kind == GLB_REQ_RD);

    // byte-strobed bank write
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            for (int b = 0; b < `GLB_STRB_WIDTH; b++) begin
                if (lane_in.req.wr.strb[b]) begin
                    bank[bank_addr][b*8 +: 8] <= lane_in.req.wr.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_valid_q  <= 1'b0;
            rdrs_valid_q <= 1'b0;
        end else begin
            req_valid_q  <= lane_in.req_valid;
            rdrs_valid_q <= rd_hit || lane_in.rdrs_valid;
        end
    end

    // a read hit never meets an upstream response in the same slot,
    // since each lane slot carries a single request
    always_ff @(posedge clk) begin
        req_kind_q <= lane_in.req_kind;
        req_q      <= lane_in.req;
        if (rd_hit) begin
            rdrs_data_q <= bank[bank_addr];
        end else begin
            rdrs_data_q <= lane_in.rdrs_data;
        end
    end

    assign lane_out.req_valid  = req_valid_q;
    assign lane_out.req_kind   = req_kind_q;
    assign lane_out.req        = req_q;
    assign lane_out.rdrs_valid = rdrs_valid_q;
    assign lane_out.rdrs_data  = rdrs_data_q;

endmodule

/* verilog/glb_rdrs_egress.sv */
/*
 * East end of the tile chain.
 * Read responses are pushed into a small FIFO and offered to the host
 * with a valid/ready pair. Each pop returns one credit to the ingress,
 * which keeps the FIFO from ever overflowing.
 */
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_rdrs_egress (
    input  logic                        clk,
    input  logic                        reset,
    glb_lane_if.dn                      lane_in,
    output logic [`GLB_DATA_WIDTH-1:0]  proc_rd_data,
    output logic                        proc_rd_data_valid,
    input  logic                        proc_rd_data_ready,
    output logic                        credit_return
);

    localparam int PTR_WIDTH = $clog2(`GLB_RDRS_DEPTH);

    logic [`GLB_DATA_WIDTH-1:0]   fifo_mem [`GLB_RDRS_DEPTH];
    logic [PTR_WIDTH-1:0]         wr_ptr;
    logic [PTR_WIDTH-1:0]         rd_ptr;
    logic [`GLB_CREDIT_WIDTH-1:0] fifo_count;
    logic                         fifo_full;
    logic                         push;
    logic                         pop;

    assign fifo_full = (fifo_count == `GLB_CREDIT_WIDTH'(`GLB_RDRS_DEPTH));

    // requests still on the lane are of no interest here
    assign push = lane_in.rdrs_valid && !fifo_full;
    assign pop  = proc_rd_data_valid && proc_rd_data_ready;

    assign proc_rd_data_valid = (fifo_count != '0);
    assign proc_rd_data       = fifo_mem[rd_ptr];

    // one credit back per response taken
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= lane_in.rdrs_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

endmodule

/* verilog/global_buffer.sv */
/*
 * Global buffer top level.
 * Host requests enter at the ingress, travel east through the tile chain
 * on lane interfaces and leave as read responses from the egress FIFO.
 * Only wiring lives here.
 */
`timescale 1ns/1ps
`include "glb_config.svh"

module global_buffer (
    input  logic                        clk,
    input  logic                        reset,

    // host write
    input  logic                        proc_wr_en,
    input  logic [`GLB_STRB_WIDTH-1:0]  proc_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]  proc_wr_data,

    // host read request
    input  logic                        proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic                        proc_rd_req_ready,

    // host read response
    output logic [`GLB_DATA_WIDTH-1:0]  proc_rd_data,
    output logic                        proc_rd_data_valid,
    input  logic                        proc_rd_data_ready
);

    logic credit_return;

    // lane i feeds tile i, the last lane feeds the egress
    glb_lane_if lane [`GLB_NUM_TILES+1] ();

    glb_proc_ingress glb_proc_ingress_inst (
        .clk               (clk),
        .reset             (reset),
        .proc_wr_en        (proc_wr_en),
        .proc_wr_strb      (proc_wr_strb),
        .proc_wr_addr      (proc_wr_addr),
        .proc_wr_data      (proc_wr_data),
        .proc_rd_en        (proc_rd_en),
        .proc_rd_addr      (proc_rd_addr),
        .proc_rd_req_ready (proc_rd_req_ready),
        .credit_return     (credit_return),
        .lane_out          (lane[0])
    );

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : glb_tile_gen
        glb_tile #(
            .TILE_ID (i)
        ) glb_tile_inst (
            .clk      (clk),
            .reset    (reset),
            .lane_in  (lane[i]),
            .lane_out (lane[i+1])
        );
    end

    glb_rdrs_egress glb_rdrs_egress_inst (
        .clk                (clk),
        .reset              (reset),
        .lane_in            (lane[`GLB_NUM_TILES]),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .proc_rd_data_ready (proc_rd_data_ready),
        .credit_return      (credit_return)
    );

endmodule

/* sim/global_buffer_checker.sv */
/*
 * Protocol assertions on the read-response egress.
 * Bound into every glb_rdrs_egress instance; fail_cnt counts assertion
 * failures so the testbench can fold them into its result.
 */
`timescale 1ns/1ps
`include "glb_config.svh"

module global_buffer_checker (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 rdrs_valid,
    input logic                                 fifo_full,
    input logic [`GLB_DATA_WIDTH-1:0]           rd_data,
    input logic                                 rd_valid,
    input logic                                 rd_ready,
    input logic [$clog2(`GLB_RDRS_DEPTH)-1:0]   rd_ptr,
    input logic                                 credit_return
);

    int fail_cnt = 0;

    // credits must keep responses away from a full FIFO
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        !(rdrs_valid && fifo_full))
    else begin
        $error("response arrived while the egress FIFO was full");
        fail_cnt++;
    end

    a_head_stable: assert property (@(posedge clk) disable iff (reset)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)))
    else begin
        $error("response head changed while the host was stalling");
        fail_cnt++;
    end

    // each credit goes with one slot freed at the FIFO head
    a_credit_pop: assert property (@(posedge clk) disable iff (reset)
        credit_return |=> (rd_ptr == $past(rd_ptr) + 1'b1))
    else begin
        $error("credit returned without a pop");
        fail_cnt++;
    end

endmodule

bind glb_rdrs_egress global_buffer_checker global_buffer_checker_inst (
    .clk           (clk),
    .reset         (reset),
    .rdrs_valid    (lane_in.rdrs_valid),
    .fifo_full     (fifo_full),
    .rd_data       (proc_rd_data),
    .rd_valid      (proc_rd_data_valid),
    .rd_ready      (proc_rd_data_ready),
    .rd_ptr        (rd_ptr),
    .credit_return (credit_return)
);

/* sim/global_buffer_tb.sv */
/*
 * Testbench for the global buffer.
 * Applies a table of host writes, reads and response stalls to the DUT,
 * predicts read data with a byte-strobed reference memory and checks the
 * responses in order as the host takes them.
 */
`timescale 1ns/1ps
`include "glb_config.svh"

module global_buffer_tb;

    typedef enum int {OP_WR, OP_RD, OP_HOLD, OP_FULL, OP_RELEASE} op_e;

    localparam int NUM_ENTRIES = 30;
    localparam int WAIT_LIMIT  = 200;

    logic                        clk;
    logic                        reset;
    logic                        proc_wr_en;
    logic [`GLB_STRB_WIDTH-1:0]  proc_wr_strb;
    logic [`GLB_ADDR_WIDTH-1:0]  proc_wr_addr;
    logic [`GLB_DATA_WIDTH-1:0]  proc_wr_data;
    logic                        proc_rd_en;
    logic [`GLB_ADDR_WIDTH-1:0]  proc_rd_addr;
    logic                        proc_rd_req_ready;
    logic [`GLB_DATA_WIDTH-1:0]  proc_rd_data;
    logic                        proc_rd_data_valid;
    logic                        proc_rd_data_ready;

    // stimulus table, expected read values filled in from the model
    string                       t_name [NUM_ENTRIES];
    op_e                         t_op   [NUM_ENTRIES];
    logic [`GLB_ADDR_WIDTH-1:0]  t_addr [NUM_ENTRIES];
    logic [`GLB_STRB_WIDTH-1:0]  t_strb [NUM_ENTRIES];
    logic [`GLB_DATA_WIDTH-1:0]  t_data [NUM_ENTRIES];
    logic [`GLB_DATA_WIDTH-1:0]  t_exp  [NUM_ENTRIES];
    int                          t_cnt;

    logic [`GLB_DATA_WIDTH-1:0]  ref_mem [2**`GLB_ADDR_WIDTH];
    logic [`GLB_DATA_WIDTH-1:0]  exp_q [$];
    string                       name_q [$];
    logic [`GLB_DATA_WIDTH-1:0]  sb_exp;
    string                       sb_name;
    logic                        hold_ready;
    logic                        ready_next;
    int                          err_cnt;
    int                          chk_cnt;

    global_buffer global_buffer_inst (.*);

    always #10 clk = ~clk;

    // host takes responses at random unless a stall is in force
    always @(posedge clk) begin
        if (hold_ready) begin
            ready_next = 1'b0;
        end else begin
            ready_next = ($urandom % 4) != 0;
        end
        #1;
        proc_rd_data_ready = ready_next;
    end

    // in-order response scoreboard
    always @(posedge clk) begin
        if (!reset && proc_rd_data_valid && proc_rd_data_ready) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("response 0x%h arrived with no read outstanding", proc_rd_data);
            end else begin
                sb_exp  = exp_q.pop_front();
                sb_name = name_q.pop_front();
                chk_cnt++;
                if (proc_rd_data !== sb_exp) begin
                    err_cnt++;
                    $display("FAIL %s: expected 0x%h, actual 0x%h",
                             sb_name, sb_exp, proc_rd_data);
                end
            end
        end
    end

    // appends one entry and advances the reference memory
    task automatic add_entry(input string name, input op_e op,
                             input logic [`GLB_ADDR_WIDTH-1:0] addr,
                             input logic [`GLB_STRB_WIDTH-1:0] strb,
                             input logic [`GLB_DATA_WIDTH-1:0] data);
        t_name[t_cnt] = name;
        t_op[t_cnt]   = op;
        t_addr[t_cnt] = addr;
        t_strb[t_cnt] = strb;
        t_data[t_cnt] = data;
        t_exp[t_cnt]  = '0;
        if (op == OP_WR) begin
            for (int b = 0; b < `GLB_STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    ref_mem[addr][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else if (op == OP_RD) begin
            t_exp[t_cnt] = ref_mem[addr];
        end
        t_cnt++;
    endtask

    task automatic build_table();
        t_cnt = 0;
        add_entry("wr_t0", OP_WR, 'h05, 'hf, 32'hdeadbeef);
        add_entry("wr_t1", OP_WR, 'h47, 'hf, 32'h12345678);
        add_entry("wr_t2", OP_WR, 'h8a, 'hf, 32'ha5a55a5a);
        add_entry("wr_t3", OP_WR, 'hff, 'hf, 32'h0badf00d);
        add_entry("rd_t0", OP_RD, 'h05, 0, 0);
        add_entry("rd_t1", OP_RD, 'h47, 0, 0);
        add_entry("rd_t2", OP_RD, 'h8a, 0, 0);
        add_entry("rd_t3", OP_RD, 'hff, 0, 0);
        add_entry("wr_base", OP_WR, 'h10, 'hf, 32'h11223344);
        add_entry("wr_strb_b0", OP_WR, 'h10, 'h1, 32'haaaaaaaa);
        add_entry("wr_strb_b2", OP_WR, 'h10, 'h4, 32'hbbbbbbbb);
        add_entry("rd_merge1", OP_RD, 'h10, 0, 0);
        add_entry("wr_strb_hi", OP_WR, 'h10, 'hc, 32'hccddeeff);
        add_entry("rd_merge2", OP_RD, 'h10, 0, 0);
        add_entry("wr_raw", OP_WR, 'hc3, 'hf, 32'h55667788);
        add_entry("rd_raw", OP_RD, 'hc3, 0, 0);
        add_entry("wr_raw_b1", OP_WR, 'hc3, 'h2, 32'h00009900);
        add_entry("rd_raw_b1", OP_RD, 'hc3, 0, 0);
        add_entry("rd_mix_t3", OP_RD, 'hff, 0, 0);
        add_entry("rd_mix_t0", OP_RD, 'h05, 0, 0);
        add_entry("rd_mix_t2", OP_RD, 'h8a, 0, 0);
        add_entry("rd_mix_t1", OP_RD, 'h47, 0, 0);
        add_entry("hold", OP_HOLD, 0, 0, 4);
        add_entry("rd_bp0", OP_RD, 'h10, 0, 0);
        add_entry("rd_bp1", OP_RD, 'hc3, 0, 0);
        add_entry("rd_bp2", OP_RD, 'h05, 0, 0);
        add_entry("rd_bp3", OP_RD, 'h47, 0, 0);
        add_entry("full", OP_FULL, 'h8a, 0, 10);
        add_entry("release", OP_RELEASE, 0, 0, 0);
        add_entry("rd_after", OP_RD, 'hff, 0, 0);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drained(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%s: %0d read responses never arrived", name, exp_q.size());
        end
    endtask

    task automatic apply_entry(input int i);
        int n;
        n = 0;
        case (t_op[i])
            OP_WR: begin
                proc_wr_en   = 1'b1;
                proc_wr_addr = t_addr[i];
                proc_wr_strb = t_strb[i];
                proc_wr_data = t_data[i];
                next_cycle();
                proc_wr_en   = 1'b0;
            end
            OP_RD: begin
                while (!proc_rd_req_ready && n < WAIT_LIMIT) begin
                    next_cycle();
                    n++;
                end
                if (!proc_rd_req_ready) begin
                    err_cnt++;
                    $display("%s: read request never became ready", t_name[i]);
                end else begin
                    proc_rd_en   = 1'b1;
                    proc_rd_addr = t_addr[i];
                    exp_q.push_back(t_exp[i]);
                    name_q.push_back(t_name[i]);
                    next_cycle();
                    proc_rd_en   = 1'b0;
                end
            end
            OP_HOLD: begin
                wait_drained(t_name[i]);
                hold_ready = 1'b1;
                repeat (t_data[i]) next_cycle();
            end
            OP_FULL: begin
                // credits are used up, so further reads must be refused
                proc_rd_en   = 1'b1;
                proc_rd_addr = t_addr[i];
                repeat (t_data[i]) begin
                    if (proc_rd_req_ready !== 1'b0) begin
                        err_cnt++;
                        $display("FAIL %s: expected ready %b, actual %b",
                                 t_name[i], 1'b0, proc_rd_req_ready);
                    end
                    next_cycle();
                end
                proc_rd_en = 1'b0;
                if (proc_rd_data_valid !== 1'b1) begin
                    err_cnt++;
                    $display("FAIL %s: expected valid %b, actual %b",
                             t_name[i], 1'b1, proc_rd_data_valid);
                end
            end
            default: begin
                hold_ready = 1'b0;
                next_cycle();
            end
        endcase
    endtask

    initial begin
        clk                = 1'b0;
        reset              = 1'b1;
        proc_wr_en         = 1'b0;
        proc_wr_strb       = '0;
        proc_wr_addr       = '0;
        proc_wr_data       = '0;
        proc_rd_en         = 1'b0;
        proc_rd_addr       = '0;
        proc_rd_data_ready = 1'b0;
        hold_ready         = 1'b0;
        err_cnt            = 0;
        chk_cnt            = 0;
        void'($urandom(94980));
        build_table();

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        if (proc_rd_data_valid !== 1'b0) begin
            err_cnt++;
            $display("FAIL after_reset_valid: expected %b, actual %b",
                     1'b0, proc_rd_data_valid);
        end
        if (proc_rd_req_ready !== 1'b1) begin
            err_cnt++;
            $display("FAIL after_reset_ready: expected %b, actual %b",
                     1'b1, proc_rd_req_ready);
        end

        for (int i = 0; i < t_cnt; i++) begin
            apply_entry(i);
        end
        wait_drained("end of table");
        repeat (4) next_cycle();

        err_cnt += global_buffer_inst.glb_rdrs_egress_inst.global_buffer_checker_inst.fail_cnt;
        $display("reads checked: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        repeat (NUM_ENTRIES * 40) @(posedge clk);
        $display("timeout: the test table did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
verilog/glb_pkg.sv
verilog/glb_lane_if.sv
verilog/glb_proc_ingress.sv
verilog/glb_tile.sv
verilog/glb_rdrs_egress.sv
verilog/global_buffer.sv
sim/global_buffer_checker.sv
sim/global_buffer_tb.sv
